// ==== Makefile ====
TOP := fetch_frontend_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module fetch_frontend
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
source/frontend_pkg.sv
source/fetch_pc_gen.sv
source/branch_target_buffer.sv
source/branch_history_table.sv
source/fetch_frontend.sv
verif/fetch_frontend_tb.sv

// ==== source/branch_history_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_history_table #(
    parameter int BTB_INDEX_WIDTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              update_valid,
    input  logic              update_taken,
    input  frontend_pkg::pc_t lookup_pc,
    input  frontend_pkg::pc_t update_pc,
    output logic              pred_taken
);
    import frontend_pkg::*;

    localparam int ENTRIES = 1 << BTB_INDEX_WIDTH;

    typedef logic [BTB_INDEX_WIDTH-1:0] index_t;
    typedef logic [1:0]                 counter_t;

    localparam counter_t CTR_WEAK_NT   = 2'd1;
    localparam counter_t CTR_STRONG_T  = 2'd3;
    localparam counter_t CTR_STRONG_NT = 2'd0;

    counter_t counter_q [ENTRIES];
    counter_t counter_next;
    index_t   lookup_idx;
    index_t   update_idx;

    assign lookup_idx = lookup_pc[BTB_INDEX_WIDTH+1:2];
    assign update_idx = update_pc[BTB_INDEX_WIDTH+1:2];

    // saturating step of the counter being trained
    always_comb begin
        counter_next = counter_q[update_idx];
        if (update_taken) begin
            if (counter_q[update_idx] != CTR_STRONG_T) begin
                counter_next = counter_q[update_idx] + 2'd1;
            end
        end else if (counter_q[update_idx] != CTR_STRONG_NT) begin
            counter_next = counter_q[update_idx] - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counter_q[i] <= CTR_WEAK_NT;
            end
        end else if (update_valid) begin
            counter_q[update_idx] <= counter_next;
        end
    end

    assign pred_taken = counter_q[lookup_idx][1]; // 2 and 3 predict taken

endmodule

`default_nettype wire

// ==== source/branch_target_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_INDEX_WIDTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              update_valid,
    input  frontend_pkg::pc_t lookup_pc,
    input  frontend_pkg::pc_t update_pc,
    input  frontend_pkg::pc_t update_target,
    output logic              btb_hit,
    output frontend_pkg::pc_t btb_target
);
    import frontend_pkg::*;

    localparam int ENTRIES   = 1 << BTB_INDEX_WIDTH;
    localparam int TAG_LSB   = BTB_INDEX_WIDTH + 2;
    localparam int TAG_WIDTH = 32 - TAG_LSB;

    typedef logic [BTB_INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0]       tag_t;

    logic [ENTRIES-1:0] valid_q;
    tag_t               tag_q    [ENTRIES];
    pc_t                target_q [ENTRIES];

    index_t lookup_idx;
    tag_t   lookup_tag;
    index_t update_idx;
    tag_t   update_tag;

    // word aligned pc, so bits [1:0] take no part in index or tag
    assign lookup_idx = lookup_pc[TAG_LSB-1:2];
    assign lookup_tag = lookup_pc[31:TAG_LSB];
    assign update_idx = update_pc[TAG_LSB-1:2];
    assign update_tag = update_pc[31:TAG_LSB];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (update_valid) begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid) begin
            tag_q[update_idx]    <= update_tag;
            target_q[update_idx] <= update_target;
        end
    end

    assign btb_hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign btb_target = target_q[lookup_idx];

endmodule

`default_nettype wire

// ==== source/fetch_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend #(
    parameter int BTB_INDEX_WIDTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 pause,
    input  logic                 branch_flush,
    input  frontend_pkg::pc_t    branch_actual_addr,
    input  logic                 exception_flush,
    input  frontend_pkg::pc_t    exception_new_pc,
    input  logic                 interrupt,
    input  logic                 update_valid,
    input  frontend_pkg::pc_t    update_pc,
    input  frontend_pkg::pc_t    update_target,
    input  logic                 update_taken,
    output frontend_pkg::pc_t    fetch_pc,
    output logic                 fetch_en,
    output logic                 fetch_uncached,
    output logic                 fetch_exc_valid,
    output frontend_pkg::ecode_t fetch_exc_code
);
    import frontend_pkg::*;

    logic btb_hit;
    pc_t  btb_target;
    logic pred_taken;

    fetch_pc_gen i_pc_gen (
        .clk                (clk),
        .rst                (rst),
        .stall              (stall),
        .pause              (pause),
        .branch_flush       (branch_flush),
        .exception_flush    (exception_flush),
        .interrupt          (interrupt),
        .btb_hit            (btb_hit),
        .pred_taken         (pred_taken),
        .branch_actual_addr (branch_actual_addr),
        .exception_new_pc   (exception_new_pc),
        .btb_target         (btb_target),
        .fetch_pc           (fetch_pc),
        .fetch_en           (fetch_en),
        .fetch_uncached     (fetch_uncached),
        .fetch_exc_valid    (fetch_exc_valid),
        .fetch_exc_code     (fetch_exc_code)
    );

    // both predictors look up the current fetch pc
    branch_target_buffer #(
        .BTB_INDEX_WIDTH (BTB_INDEX_WIDTH)
    ) i_btb (
        .clk           (clk),
        .rst           (rst),
        .update_valid  (update_valid),
        .lookup_pc     (fetch_pc),
        .update_pc     (update_pc),
        .update_target (update_target),
        .btb_hit       (btb_hit),
        .btb_target    (btb_target)
    );

    branch_history_table #(
        .BTB_INDEX_WIDTH (BTB_INDEX_WIDTH)
    ) i_bht (
        .clk          (clk),
        .rst          (rst),
        .update_valid (update_valid),
        .update_taken (update_taken),
        .lookup_pc    (fetch_pc),
        .update_pc    (update_pc),
        .pred_taken   (pred_taken)
    );

endmodule

`default_nettype wire

// ==== source/fetch_pc_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   pause,
    input  logic                   branch_flush,
    input  logic                   exception_flush,
    input  logic                   interrupt,
    input  logic                   btb_hit,
    input  logic                   pred_taken,
    input  frontend_pkg::pc_t      branch_actual_addr,
    input  frontend_pkg::pc_t      exception_new_pc,
    input  frontend_pkg::pc_t      btb_target,
    output frontend_pkg::pc_t      fetch_pc,
    output logic                   fetch_en,
    output logic                   fetch_uncached,
    output logic                   fetch_exc_valid,
    output frontend_pkg::ecode_t   fetch_exc_code
);
    import frontend_pkg::*;

    pc_t  pc_q;
    pc_t  pc_next;
    pc_t  pc_seq;
    logic pause_q; // pause seen in the previous cycle
    logic int_q;   // registered interrupt level
    logic misaligned;

    assign pc_seq = pc_q + PC_STEP;

    always_comb begin
        pc_next = pc_seq;
        if (exception_flush) begin
            pc_next = exception_new_pc;
        end else if (pause) begin
            // a fresh pause lets the current fetch advance once
            if (pause_q || stall) begin
                pc_next = pc_q;
            end else begin
                pc_next = pc_seq;
            end
        end else if (branch_flush) begin
            pc_next = branch_actual_addr;
        end else if (stall) begin
            pc_next = pc_q;
        end else if (btb_hit && pred_taken) begin
            pc_next = btb_target; // predicted taken
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= RESET_PC;
            pause_q <= 1'b0;
            int_q   <= 1'b0;
        end else begin
            pc_q    <= pc_next;
            pause_q <= pause;
            int_q   <= interrupt;
        end
    end

    assign fetch_pc       = pc_q;
    assign fetch_uncached = (pc_q <= UNCACHED_LIMIT);
    assign fetch_en       = ~fetch_uncached;

    assign misaligned = (pc_q[1:0] != 2'b00);

    // interrupt outranks a misaligned address
    always_comb begin
        if (int_q) begin
            fetch_exc_valid = 1'b1;
            fetch_exc_code  = ECODE_INT;
        end else if (misaligned) begin
            fetch_exc_valid = 1'b1;
            fetch_exc_code  = ECODE_ADEF;
        end else begin
            fetch_exc_valid = 1'b0;
            fetch_exc_code  = ECODE_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== source/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    // instruction fetch address
    typedef logic [31:0] pc_t;

    // exception cause code
    typedef logic [5:0] ecode_t;

    // first sequential step from here lands on 32'h1c000000
    localparam pc_t RESET_PC = 32'h1bfffffc;

    // fetches at or below this address bypass the cache
    localparam pc_t UNCACHED_LIMIT = 32'h1c000100;

    // distance between two sequential fetches
    localparam pc_t PC_STEP = 32'd4;

    localparam ecode_t ECODE_NONE = 6'h00; // no fetch exception
    localparam ecode_t ECODE_INT  = 6'h00; // interrupt
    localparam ecode_t ECODE_ADEF = 6'h08; // misaligned fetch address

endpackage

`default_nettype wire

// ==== verif/fetch_frontend_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend_tb;
    import frontend_pkg::*;

    localparam int    NUM_LINES      = 37;
    localparam int    WORDS_PER_LINE = 7;
    localparam int    RESET_TIMEOUT  = 20;
    localparam int    TIMEOUT_NS     = (NUM_LINES + 40) * 4;
    localparam string STIM_FILE      = "verif/fetch_stimulus.txt";

    // word offsets within one stimulus line
    localparam int W_CTRL  = 0;
    localparam int W_BADDR = 1;
    localparam int W_EADDR = 2;
    localparam int W_UPC   = 3;
    localparam int W_UTGT  = 4;
    localparam int W_EXPPC = 5;
    localparam int W_FLAGS = 6;

    logic   clk = 1'b0;
    logic   rst;
    logic   stall;
    logic   pause;
    logic   branch_flush;
    pc_t    branch_actual_addr;
    logic   exception_flush;
    pc_t    exception_new_pc;
    logic   interrupt;
    logic   update_valid;
    pc_t    update_pc;
    pc_t    update_target;
    logic   update_taken;
    pc_t    fetch_pc;
    logic   fetch_en;
    logic   fetch_uncached;
    logic   fetch_exc_valid;
    ecode_t fetch_exc_code;

    logic [31:0] stim_mem [NUM_LINES*WORDS_PER_LINE];

    int mismatch_count = 0;
    int other_errors   = 0;

    fetch_frontend #(
        .BTB_INDEX_WIDTH (4)
    ) i_dut (
        .clk                (clk),
        .rst                (rst),
        .stall              (stall),
        .pause              (pause),
        .branch_flush       (branch_flush),
        .branch_actual_addr (branch_actual_addr),
        .exception_flush    (exception_flush),
        .exception_new_pc   (exception_new_pc),
        .interrupt          (interrupt),
        .update_valid       (update_valid),
        .update_pc          (update_pc),
        .update_target      (update_target),
        .update_taken       (update_taken),
        .fetch_pc           (fetch_pc),
        .fetch_en           (fetch_en),
        .fetch_uncached     (fetch_uncached),
        .fetch_exc_valid    (fetch_exc_valid),
        .fetch_exc_code     (fetch_exc_code)
    );

    always #2 clk = ~clk; // 4 ns period

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // last expected pc of the file is never zero
    function automatic logic stimulus_loaded();
        logic [31:0] last_pc;
        last_pc = stim_mem[(NUM_LINES-1)*WORDS_PER_LINE + W_EXPPC];
        return !($isunknown(last_pc) || last_pc == 32'd0);
    endfunction

    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        released = (rst === 1'b0);
        if (!released) begin
            other_errors++;
            $display("reset was still asserted after %0d cycles", RESET_TIMEOUT);
        end
    endtask

    task automatic check_reset_state();
        check_value("fetch_pc", RESET_PC, fetch_pc);
        check_value("fetch_en", 32'd0, {31'd0, fetch_en});
        check_value("fetch_uncached", 32'd1, {31'd0, fetch_uncached});
        check_value("fetch_exc_valid", 32'd0, {31'd0, fetch_exc_valid});
        check_value("fetch_exc_code", 32'd0, {26'd0, fetch_exc_code});
    endtask

    // ctrl word keeps one hex digit per flag
    task automatic drive_line(input int idx);
        int          base;
        logic [31:0] ctrl;
        base = idx * WORDS_PER_LINE;
        ctrl = stim_mem[base + W_CTRL];
        stall              <= ctrl[24];
        pause              <= ctrl[20];
        branch_flush       <= ctrl[16];
        exception_flush    <= ctrl[12];
        interrupt          <= ctrl[8];
        update_valid       <= ctrl[4];
        update_taken       <= ctrl[0];
        branch_actual_addr <= stim_mem[base + W_BADDR];
        exception_new_pc   <= stim_mem[base + W_EADDR];
        update_pc          <= stim_mem[base + W_UPC];
        update_target      <= stim_mem[base + W_UTGT];
    endtask

    task automatic check_line(input int idx);
        int          base;
        logic [31:0] flags;
        base  = idx * WORDS_PER_LINE;
        flags = stim_mem[base + W_FLAGS]; // en, exc_valid, two digit code
        check_value("fetch_pc", stim_mem[base + W_EXPPC], fetch_pc);
        check_value("fetch_en", {31'd0, flags[12]}, {31'd0, fetch_en});
        check_value("fetch_uncached", {31'd0, !flags[12]}, {31'd0, fetch_uncached});
        check_value("fetch_exc_valid", {31'd0, flags[8]}, {31'd0, fetch_exc_valid});
        check_value("fetch_exc_code", {24'd0, flags[7:0]}, {26'd0, fetch_exc_code});
    endtask

    initial begin
        logic released;
        int   line_idx;
        rst                = 1'b1;
        stall              = 1'b0;
        pause              = 1'b0;
        branch_flush       = 1'b0;
        branch_actual_addr = '0;
        exception_flush    = 1'b0;
        exception_new_pc   = '0;
        interrupt          = 1'b0;
        update_valid       = 1'b0;
        update_pc          = '0;
        update_target      = '0;
        update_taken       = 1'b0;
        $readmemh(STIM_FILE, stim_mem);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait_reset_release(released);
        if (!released) begin
            $display("skipping the stimulus because reset never ended");
        end else if (!stimulus_loaded()) begin
            other_errors++;
            $display("stimulus file %s is missing or shorter than expected", STIM_FILE);
        end else begin
            check_reset_state();
            // line n is driven one edge before the edge that samples it
            for (line_idx = 0; line_idx <= NUM_LINES; line_idx++) begin
                @(posedge clk);
                if (line_idx < NUM_LINES) begin
                    drive_line(line_idx);
                end
                @(negedge clk);
                if (line_idx > 0) begin
                    check_line(line_idx - 1);
                end
            end
        end
        finish_run();
    end

    initial begin
        #(TIMEOUT_NS);
        other_errors++;
        $display("simulation did not finish within %0d ns", TIMEOUT_NS);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== verif/fetch_stimulus.txt ====
// ctrl digits: stall pause branch_flush exception_flush interrupt update_valid update_taken
// then branch_addr exc_new_pc update_pc update_target exp_fetch_pc exp_flags (en exc_valid code)
0000000 00000000 00000000 00000000 00000000 1c000004 0000
0000000 00000000 00000000 00000000 00000000 1c000008 0000
0010000 1c0000f8 00000000 00000000 00000000 1c0000f8 0000
0000000 00000000 00000000 00000000 00000000 1c0000fc 0000
0000000 00000000 00000000 00000000 00000000 1c000100 0000
0000000 00000000 00000000 00000000 00000000 1c000104 1000
1000000 00000000 00000000 00000000 00000000 1c000104 1000
1000000 00000000 00000000 00000000 00000000 1c000104 1000
0100000 00000000 00000000 00000000 00000000 1c000108 1000
0100000 00000000 00000000 00000000 00000000 1c000108 1000
0110000 1c000400 00000000 00000000 00000000 1c000108 1000
0000000 00000000 00000000 00000000 00000000 1c00010c 1000
1100000 00000000 00000000 00000000 00000000 1c00010c 1000
0000000 00000000 00000000 00000000 00000000 1c000110 1000
0010000 1c000200 00000000 00000000 00000000 1c000200 1000
0011000 1c000300 1c000500 00000000 00000000 1c000500 1000
0000000 00000000 00000000 00000000 00000000 1c000504 1000
0000000 00000000 00000000 00000000 00000000 1c000508 1000
0000000 00000000 00000000 00000000 00000000 1c00050c 1000
0000011 00000000 00000000 1c000508 1c000800 1c000510 1000
0010000 1c000508 00000000 00000000 00000000 1c000508 1000
0000000 00000000 00000000 00000000 00000000 1c000800 1000
0000000 00000000 00000000 00000000 00000000 1c000804 1000
0000010 00000000 00000000 1c000508 1c000800 1c000808 1000
0000010 00000000 00000000 1c000508 1c000800 1c00080c 1000
0010000 1c000508 00000000 00000000 00000000 1c000508 1000
0000000 00000000 00000000 00000000 00000000 1c00050c 1000
0001000 00000000 1c000602 00000000 00000000 1c000602 1108
0000000 00000000 00000000 00000000 00000000 1c000606 1108
0000100 00000000 00000000 00000000 00000000 1c00060a 1100
0000100 00000000 00000000 00000000 00000000 1c00060e 1100
0001100 00000000 1c000700 00000000 00000000 1c000700 1100
0000000 00000000 00000000 00000000 00000000 1c000704 1000
0000000 00000000 00000000 00000000 00000000 1c000708 1000
0101000 00000000 1c000900 00000000 00000000 1c000900 1000
0100000 00000000 00000000 00000000 00000000 1c000900 1000
0000000 00000000 00000000 00000000 00000000 1c000904 1000
